//--- build.f
+incdir+.
periph_pkg.sv
apb_decode.sv
mem_bank.sv
clint_regs.sv
apb_response.sv
periph_subsys.sv
tb_periph_subsys.sv

//--- Makefile
# Verilator build and run of the peripheral block testbench

VERILATOR ?= verilator
TOP       ?= tb_periph_subsys
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# the simulator exit status carries pass or fail
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_tasks.svh
// APB driver, compare tasks and directed tests, included inside the testbench module
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_word(input string tn, input logic [periph_pkg::ApbDataWidth-1:0] exp,
                            input logic [periph_pkg::ApbDataWidth-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected %h actual %h", tn, exp, act);
      $display("TB FAILED");
      $fatal(1, "data compare failed");
    end
  endtask

  task automatic check_err(input string tn, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s pslverr expected %b actual %b", tn, exp, act);
      $display("TB FAILED");
      $fatal(1, "pslverr compare failed");
    end
  endtask

  task automatic check_mip(input string tn, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s mip expected %h actual %h", tn, exp, act);
      $display("TB FAILED");
      $fatal(1, "mip compare failed");
    end
  endtask

  // msip, mtip and meip sit at mip bits 3, 7 and 11
  function automatic logic [31:0] expected_mip(input logic msip, input logic mtip,
                                               input logic meip);
    logic [31:0] v;
    v     = '0;
    v[3]  = msip;
    v[7]  = mtip;
    v[11] = meip;
    return v;
  endfunction

  function automatic logic [31:0] clint_addr(input logic [15:0] off);
    return periph_pkg::ClintBase + {16'b0, off};
  endfunction

  // ------------------------------
  // APB driver
  // ------------------------------
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] strb,
                              output logic [31:0] rdata, output logic slverr,
                              output int unsigned acc_cycles);
    @(negedge clk_i);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pstrb   = write ? strb : 4'h0;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    acc_cycles      = 1;
    // pready seen here completes the transfer on the next rising edge
    while (!apb_rsp.pready) begin
      if (acc_cycles >= MaxAccessCycles) begin
        $display("no pready by access cycle %0d at address %h", acc_cycles, addr);
        $display("TB FAILED");
        $fatal(1, "apb transfer stalled");
      end else begin
        @(negedge clk_i);
        acc_cycles++;
      end
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge clk_i);
    apb_req = '0;
  endtask

  task automatic write_word(input string tn, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
    logic [31:0] rdata;
    logic        err;
    int unsigned acc;
    apb_transfer(1'b1, addr, data, strb, rdata, err, acc);
    check_err(tn, 1'b0, err);
  endtask

  task automatic read_word(input string tn, input logic [31:0] addr,
                           output logic [31:0] data);
    logic        err;
    int unsigned acc;
    apb_transfer(1'b0, addr, 32'h0, 4'h0, data, err, acc);
    check_err(tn, 1'b0, err);
  endtask

  // rtc pulses of 4 cycles high and 4 low
  task automatic pulse_rtc(input int unsigned count);
    @(negedge clk_i);
    for (int i = 0; i < count; i++) begin
      rtc_i = 1'b1;
      repeat (4) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (4) @(negedge clk_i);
    end
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_mem_rw();
    string               tn = "test_mem_rw";
    logic [31:0]         model [MemWords];
    logic [IdxWidth-1:0] idx_list [16];
    logic [31:0]         rnd;
    logic [31:0]         data;
    for (int i = 0; i < 16; i++) begin
      rnd                = $random(seed);
      idx_list[i]        = rnd[IdxWidth-1:0];
      data               = $random(seed);
      model[idx_list[i]] = data;
      write_word(tn, periph_pkg::MemBase + (32'(idx_list[i]) << 2), data, 4'hf);
    end
    // repeated indices read back their last write
    for (int i = 0; i < 16; i++) begin
      read_word(tn, periph_pkg::MemBase + (32'(idx_list[i]) << 2), data);
      check_word(tn, model[idx_list[i]], data);
    end
  endtask

  task automatic test_mem_strobe();
    string       tn   = "test_mem_strobe";
    logic [31:0] addr = periph_pkg::MemBase + 32'h40;
    logic [31:0] old_word;
    logic [31:0] new_word;
    logic [31:0] data;
    old_word = $random(seed);
    new_word = ~old_word;
    write_word(tn, addr, old_word, 4'hf);
    write_word(tn, addr, new_word, 4'b0101);
    read_word(tn, addr, data);
    check_word(tn, {old_word[31:24], new_word[23:16], old_word[15:8], new_word[7:0]}, data);
  endtask

  task automatic test_error_region();
    string       tn = "test_error_region";
    logic [31:0] bad_addr [3];
    logic [31:0] rdata;
    logic        err;
    int unsigned acc;
    bad_addr[0] = 32'h1000_0000;
    bad_addr[1] = periph_pkg::MemBase + 32'(MemWords * 4);
    bad_addr[2] = periph_pkg::MemBase + 32'h2;
    for (int i = 0; i < 3; i++) begin
      for (int w = 0; w < 2; w++) begin
        apb_transfer(w[0], bad_addr[i], $random(seed), 4'hf, rdata, err, acc);
        check_err(tn, 1'b1, err);
        check_word(tn, 32'h0, rdata);
        check_word(tn, 32'd2, 32'(acc));
      end
    end
  endtask

  task automatic test_soft_and_ext_irq();
    string tn = "test_soft_and_ext_irq";
    write_word(tn, clint_addr(periph_pkg::MsipOff), 32'h1, 4'hf);
    check_mip(tn, expected_mip(1'b1, 1'b0, 1'b0), mip);
    write_word(tn, clint_addr(periph_pkg::MsipOff), 32'h0, 4'hf);
    check_mip(tn, expected_mip(1'b0, 1'b0, 1'b0), mip);
    ext_irq_i = 1'b1;
    @(negedge clk_i);
    check_mip(tn, expected_mip(1'b0, 1'b0, 1'b1), mip);
    ext_irq_i = 1'b0;
    @(negedge clk_i);
    check_mip(tn, expected_mip(1'b0, 1'b0, 1'b0), mip);
  endtask

  task automatic test_timer();
    string       tn = "test_timer";
    logic [63:0] mtime_exp;
    logic [31:0] data;
    check_mip(tn, expected_mip(1'b0, 1'b0, 1'b0), mip);
    read_word(tn, clint_addr(periph_pkg::MtimeLoOff), data);
    check_word(tn, 32'h0, data);
    read_word(tn, clint_addr(periph_pkg::MtimeHiOff), data);
    check_word(tn, 32'h0, data);
    // start just below the carry into the upper half
    mtime_exp = 64'h0000_0000_ffff_fffe;
    write_word(tn, clint_addr(periph_pkg::MtimeLoOff), mtime_exp[31:0], 4'hf);
    write_word(tn, clint_addr(periph_pkg::MtimeHiOff), mtime_exp[63:32], 4'hf);
    write_word(tn, clint_addr(periph_pkg::MtimecmpLoOff), 32'h0000_0001, 4'hf);
    write_word(tn, clint_addr(periph_pkg::MtimecmpHiOff), 32'h0000_0001, 4'hf);
    pulse_rtc(3);
    mtime_exp = mtime_exp + 64'd3;
    read_word(tn, clint_addr(periph_pkg::MtimeLoOff), data);
    check_word(tn, mtime_exp[31:0], data);
    read_word(tn, clint_addr(periph_pkg::MtimeHiOff), data);
    check_word(tn, mtime_exp[63:32], data);
    check_mip(tn, expected_mip(1'b0, 1'b1, 1'b0), mip);
    write_word(tn, clint_addr(periph_pkg::MtimecmpHiOff), 32'h0000_0002, 4'hf);
    check_mip(tn, expected_mip(1'b0, 1'b0, 1'b0), mip);
  endtask

`endif

//--- tb_periph_subsys.sv
// testbench for the APB peripheral block, runs the directed tests through the APB port
`timescale 1ns/1ps

module tb_periph_subsys;

  localparam int unsigned MemWords        = 256;
  localparam int unsigned IdxWidth        = $clog2(MemWords);
  localparam int unsigned NumTests        = 5;
  localparam int unsigned CyclesPerTest   = 2000;
  localparam int unsigned MaxAccessCycles = 2;
  localparam int unsigned HalfPeriod      = 50;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 rtc_i;
  logic                 ext_irq_i;
  periph_pkg::apb_req_t apb_req;
  periph_pkg::apb_rsp_t apb_rsp;
  logic [31:0]          mip;
  integer               seed;

  periph_subsys dut_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .rtc_i     ( rtc_i     ),
    .ext_irq_i ( ext_irq_i ),
    .apb_req_i ( apb_req   ),
    .apb_rsp_o ( apb_rsp   ),
    .mip_o     ( mip       )
  );

  `include "tb_tasks.svh"

  // 100 ns clock
  initial begin
    clk_i = 1'b0;
    forever #HalfPeriod clk_i = ~clk_i;
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    repeat (NumTests * CyclesPerTest) @(posedge clk_i);
    $display("watchdog expired before the test sequence finished");
    $display("TB FAILED");
    $fatal(1, "watchdog timeout");
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    rst_ni    = 1'b0;
    rtc_i     = 1'b0;
    ext_irq_i = 1'b0;
    apb_req   = '0;
    seed      = 32'hb47e;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    test_mem_rw();
    test_mem_strobe();
    test_error_region();
    test_soft_and_ext_irq();
    // rtc stays low until here, so mtime is still at its reset value
    test_timer();

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- periph_subsys.sv
// APB-attached peripheral block with scratch RAM, CLINT and the machine irq vector
`timescale 1ns/1ps

module periph_subsys #(
  parameter int unsigned MemWords = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rtc_i,
  input  logic                  ext_irq_i,
  input  periph_pkg::apb_req_t  apb_req_i,
  output periph_pkg::apb_rsp_t  apb_rsp_o,
  output logic [31:0]           mip_o
);

  periph_pkg::bus_req_t bus_req;
  periph_pkg::bus_rsp_t mem_rsp;
  periph_pkg::bus_rsp_t clint_rsp;
  logic                 xfer_done;
  logic                 timer_irq;
  logic                 soft_irq;

  apb_decode #(
    .MemWords ( MemWords )
  ) i_apb_decode (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .apb_req_i   ( apb_req_i ),
    .xfer_done_i ( xfer_done ),
    .bus_req_o   ( bus_req   )
  );

  mem_bank #(
    .MemWords ( MemWords )
  ) i_mem_bank (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .bus_req_i ( bus_req ),
    .bus_rsp_o ( mem_rsp )
  );

  clint_regs i_clint_regs (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .rtc_i       ( rtc_i     ),
    .bus_req_i   ( bus_req   ),
    .bus_rsp_o   ( clint_rsp ),
    .timer_irq_o ( timer_irq ),
    .soft_irq_o  ( soft_irq  )
  );

  apb_response i_apb_response (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .bus_req_i   ( bus_req   ),
    .mem_rsp_i   ( mem_rsp   ),
    .clint_rsp_i ( clint_rsp ),
    .apb_rsp_o   ( apb_rsp_o ),
    .xfer_done_o ( xfer_done )
  );

  // msip, mtip and meip at their standard mip positions
  always_comb begin
    mip_o                         = '0;
    mip_o[periph_pkg::IrqMsipBit] = soft_irq;
    mip_o[periph_pkg::IrqMtipBit] = timer_irq;
    mip_o[periph_pkg::IrqMeipBit] = ext_irq_i;
  end

endmodule

//--- apb_response.sv
// merges target replies and the error path into the APB completer response
`timescale 1ns/1ps

module apb_response (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  periph_pkg::bus_req_t  bus_req_i,
  input  periph_pkg::bus_rsp_t  mem_rsp_i,
  input  periph_pkg::bus_rsp_t  clint_rsp_i,
  output periph_pkg::apb_rsp_t  apb_rsp_o,
  output logic                  xfer_done_o
);

  logic err_q;
  logic pready;

  // error region answers in the same slot a target would
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_req_i.valid && (bus_req_i.region == periph_pkg::REGION_ERR);
    end
  end

  assign pready = mem_rsp_i.valid || clint_rsp_i.valid || err_q;

  always_comb begin
    apb_rsp_o.prdata = '0;
    if (mem_rsp_i.valid) begin
      apb_rsp_o.prdata = mem_rsp_i.rdata;
    end else if (clint_rsp_i.valid) begin
      apb_rsp_o.prdata = clint_rsp_i.rdata;
    end
    apb_rsp_o.pready  = pready;
    apb_rsp_o.pslverr = err_q;
  end

  assign xfer_done_o = pready;

  // ------------------------------
  // one pready per request pulse
  // ------------------------------
  a_pready_after_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus_req_i.valid |=> pready
  );

  a_pready_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pready |-> $past(bus_req_i.valid) ##1 !pready
  );

endmodule

//--- clint_regs.sv
// CLINT target with msip, mtimecmp and an rtc-driven mtime, raises soft and timer irqs
`timescale 1ns/1ps

module clint_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rtc_i,
  input  periph_pkg::bus_req_t  bus_req_i,
  output periph_pkg::bus_rsp_t  bus_rsp_o,
  output logic                  timer_irq_o,
  output logic                  soft_irq_o
);

  logic [1:0]  rtc_sync_q;
  logic        rtc_prev_q;
  logic        rtc_rise;
  logic        msip_q;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtime_q;
  logic        timer_irq_q;
  logic        sel;
  logic        wr_en;
  logic [31:0] cur_word;
  logic [31:0] wr_word;
  logic        valid_q;
  logic [31:0] rdata_q;

  // ------------------------------
  // rtc crossing
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_rise = rtc_sync_q[1] && !rtc_prev_q;

  // ------------------------------
  // register access
  // ------------------------------
  assign sel   = bus_req_i.valid && (bus_req_i.region == periph_pkg::REGION_CLINT);
  assign wr_en = sel && (bus_req_i.op == periph_pkg::OP_WRITE);

  always_comb begin
    cur_word = '0;
    case (bus_req_i.offset)
      periph_pkg::MsipOff:       cur_word = {31'b0, msip_q};
      periph_pkg::MtimecmpLoOff: cur_word = mtimecmp_q[31:0];
      periph_pkg::MtimecmpHiOff: cur_word = mtimecmp_q[63:32];
      periph_pkg::MtimeLoOff:    cur_word = mtime_q[31:0];
      periph_pkg::MtimeHiOff:    cur_word = mtime_q[63:32];
      default:                   cur_word = '0;
    endcase
  end

  // partial writes keep the untouched bytes
  assign wr_word = periph_pkg::merge_bytes(cur_word, bus_req_i.wdata, bus_req_i.strb);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (wr_en && bus_req_i.offset == periph_pkg::MsipOff) begin
        msip_q <= wr_word[0];
      end
      if (wr_en && bus_req_i.offset == periph_pkg::MtimecmpLoOff) begin
        mtimecmp_q[31:0] <= wr_word;
      end
      if (wr_en && bus_req_i.offset == periph_pkg::MtimecmpHiOff) begin
        mtimecmp_q[63:32] <= wr_word;
      end
      // bus write wins over a tick in the same cycle
      if (wr_en && bus_req_i.offset == periph_pkg::MtimeLoOff) begin
        mtime_q[31:0] <= wr_word;
      end else if (wr_en && bus_req_i.offset == periph_pkg::MtimeHiOff) begin
        mtime_q[63:32] <= wr_word;
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  // compare registered, follows either register by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      timer_irq_q <= 1'b0;
      valid_q     <= 1'b0;
    end else begin
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      valid_q     <= sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel) begin
      rdata_q <= (bus_req_i.op == periph_pkg::OP_READ) ? cur_word : '0;
    end
  end

  assign bus_rsp_o.valid = valid_q;
  assign bus_rsp_o.rdata = rdata_q;
  assign timer_irq_o     = timer_irq_q;
  assign soft_irq_o      = msip_q;

  // an answer lasts one cycle, requests arrive one at a time
  a_rsp_single_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus_rsp_o.valid |=> !bus_rsp_o.valid
  );

endmodule

//--- mem_bank.sv
// scratch RAM target with byte strobes, answers one cycle after the request
`timescale 1ns/1ps

module mem_bank #(
  parameter int unsigned MemWords = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  periph_pkg::bus_req_t  bus_req_i,
  output periph_pkg::bus_rsp_t  bus_rsp_o
);

  localparam int unsigned IdxWidth = $clog2(MemWords);

  logic [periph_pkg::ApbDataWidth-1:0] mem_q [MemWords];
  logic [periph_pkg::ApbDataWidth-1:0] rdata_q;
  logic                                valid_q;
  logic                                sel;
  logic [IdxWidth-1:0]                 idx;

  assign sel = bus_req_i.valid && (bus_req_i.region == periph_pkg::REGION_MEM);
  // word index from the byte offset
  assign idx = bus_req_i.offset[IdxWidth+1:2];

  // array and read data
  always_ff @(posedge clk_i) begin
    if (sel) begin
      if (bus_req_i.op == periph_pkg::OP_WRITE) begin
        mem_q[idx] <= periph_pkg::merge_bytes(mem_q[idx], bus_req_i.wdata, bus_req_i.strb);
        rdata_q    <= '0;
      end else begin
        rdata_q    <= mem_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sel;
    end
  end

  assign bus_rsp_o.valid = valid_q;
  assign bus_rsp_o.rdata = rdata_q;

endmodule

//--- apb_decode.sv
// tracks APB phases and turns each transfer into one decoded request pulse
`timescale 1ns/1ps

module apb_decode #(
  parameter int unsigned MemWords = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  periph_pkg::apb_req_t  apb_req_i,
  input  logic                  xfer_done_i,
  output periph_pkg::bus_req_t  bus_req_o
);

  localparam logic [31:0] MemBytes = 32'(MemWords) * 32'd4;

  typedef enum logic [1:0] {
    IDLE,
    ISSUED,
    WAIT_DONE
  } state_e;

  state_e               state_q, state_d;
  periph_pkg::bus_req_t dec_req;
  periph_pkg::bus_req_t req_q;
  logic [31:0]          rel_addr;
  logic                 capture;

  // ------------------------------
  // address decode
  // ------------------------------
  always_comb begin
    dec_req        = '0;
    dec_req.valid  = 1'b1;
    dec_req.op     = apb_req_i.pwrite ? periph_pkg::OP_WRITE : periph_pkg::OP_READ;
    dec_req.wdata  = apb_req_i.pwdata;
    // strobes only mean something on writes
    dec_req.strb   = apb_req_i.pwrite ? apb_req_i.pstrb : '0;
    rel_addr       = '0;
    dec_req.region = periph_pkg::REGION_ERR;
    if (apb_req_i.paddr[1:0] != 2'b00) begin
      dec_req.region = periph_pkg::REGION_ERR;
    end else if (apb_req_i.paddr < periph_pkg::MemBase + MemBytes) begin
      dec_req.region = periph_pkg::REGION_MEM;
      rel_addr       = apb_req_i.paddr - periph_pkg::MemBase;
    end else if (apb_req_i.paddr >= periph_pkg::ClintBase &&
                 apb_req_i.paddr < periph_pkg::ClintBase + periph_pkg::ClintLength) begin
      dec_req.region = periph_pkg::REGION_CLINT;
      rel_addr       = apb_req_i.paddr - periph_pkg::ClintBase;
    end
    dec_req.offset = rel_addr[15:0];
  end

  // ------------------------------
  // phase FSM
  // ------------------------------
  // setup phase is latched so the pulse lands in the first access cycle
  assign capture = (state_q == IDLE) && apb_req_i.psel && !apb_req_i.penable;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:      if (capture) state_d = ISSUED;
      ISSUED:    state_d = WAIT_DONE;
      WAIT_DONE: if (xfer_done_i) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      req_q <= dec_req;
    end
  end

  always_comb begin
    bus_req_o       = req_q;
    bus_req_o.valid = (state_q == ISSUED);
  end

  // requester protocol check
  a_penable_needs_psel: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    apb_req_i.penable |-> apb_req_i.psel
  );

endmodule

//--- periph_pkg.sv
// shared address map, bus widths, enums and structs for the APB peripheral block
package periph_pkg;

  // ------------------------------
  // bus widths
  // ------------------------------
  localparam int unsigned ApbAddrWidth = 32;
  localparam int unsigned ApbDataWidth = 32;
  localparam int unsigned ApbStrbWidth = 4;

  // ------------------------------
  // address map
  // ------------------------------
  localparam logic [31:0] MemBase     = 32'h0000_0000;
  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] ClintLength = 32'h0001_0000;

  // clint register offsets
  localparam logic [15:0] MsipOff       = 16'h0000;
  localparam logic [15:0] MtimecmpLoOff = 16'h4000;
  localparam logic [15:0] MtimecmpHiOff = 16'h4004;
  localparam logic [15:0] MtimeLoOff    = 16'hBFF8;
  localparam logic [15:0] MtimeHiOff    = 16'hBFFC;

  // positions in the machine interrupt-pending vector
  localparam int unsigned IrqMsipBit = 3;
  localparam int unsigned IrqMtipBit = 7;
  localparam int unsigned IrqMeipBit = 11;

  typedef enum logic [1:0] {
    REGION_MEM,
    REGION_CLINT,
    REGION_ERR
  } region_e;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } access_op_e;

  // requester side of APB4
  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [ApbAddrWidth-1:0] paddr;
    logic [ApbDataWidth-1:0] pwdata;
    logic [ApbStrbWidth-1:0] pstrb;
  } apb_req_t;

  // completer side of APB4
  typedef struct packed {
    logic [ApbDataWidth-1:0] prdata;
    logic                    pready;
    logic                    pslverr;
  } apb_rsp_t;

  // decoded request, valid is a single-cycle pulse
  typedef struct packed {
    logic                    valid;
    access_op_e              op;
    region_e                 region;
    logic [15:0]             offset;
    logic [ApbDataWidth-1:0] wdata;
    logic [ApbStrbWidth-1:0] strb;
  } bus_req_t;

  typedef struct packed {
    logic                    valid;
    logic [ApbDataWidth-1:0] rdata;
  } bus_rsp_t;

  // byte-lane merge of write data into an existing word
  function automatic logic [ApbDataWidth-1:0] merge_bytes(
    input logic [ApbDataWidth-1:0] old_word,
    input logic [ApbDataWidth-1:0] new_word,
    input logic [ApbStrbWidth-1:0] strb
  );
    logic [ApbDataWidth-1:0] res;
    res = old_word;
    for (int i = 0; i < ApbStrbWidth; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage
